/* hdl/buffer_port.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_port (
  input  wire                              OPB_Clk,
  input  wire                              reset,
  input  wire                              trans,
  input  wire fabric_pkg::opb_req_t        req,
  input  wire [fabric_pkg::TX_W-1:0]       tx_rd_word,
  input  wire [fabric_pkg::ARP_W-1:0]      arp_rd_word,
  output logic [fabric_pkg::BUF_AW-1:0]    buf_addr,
  output logic [fabric_pkg::TX_W-1:0]      wr_word,
  output logic                             tx_we,
  output logic                             arp_we
);

  logic        is_tx;
  logic        is_arp;
  logic        lo;
  logic        wr;
  logic [3:0]  be_eff;
  logic [63:0] cur_word;
  logic [31:0] cur_half;
  logic [31:0] new_half;
  logic [63:0] next_word;

  assign buf_addr = req.offset[10:3];
  assign lo       = req.offset[2];
  assign is_tx    = (req.region == fabric_pkg::rgn_tx);
  assign is_arp   = (req.region == fabric_pkg::rgn_arp);
  assign wr       = trans && !req.rnw;

  // arp entry zero-extended so both memories share the merge
  assign cur_word = is_arp ? {16'b0, arp_rd_word} : tx_rd_word;

  // upper arp half holds only bits 47:32
  assign be_eff = (is_arp && !lo) ? (req.be & 4'b0011) : req.be;

  assign cur_half = fabric_pkg::half_sel(cur_word, lo);
  assign new_half = fabric_pkg::be_merge(cur_half, req.wdata, be_eff);

  always_comb begin
    if (lo) begin
      next_word = {cur_word[63:32], new_half};
    end else begin
      next_word = {new_half, cur_word[31:0]};
    end
  end

  // strobes are high during the ack cycle, memory updates on the next edge
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      tx_we  <= 1'b0;
      arp_we <= 1'b0;
    end else begin
      tx_we  <= wr && is_tx;
      arp_we <= wr && is_arp;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (wr) begin
      wr_word <= next_word;
    end
  end

endmodule

`default_nettype wire

/* hdl/cpu_buffers.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_buffers (
  input  wire                              OPB_Clk,
  input  wire [fabric_pkg::BUF_AW-1:0]     buf_addr,
  input  wire [fabric_pkg::TX_W-1:0]       wr_word,
  input  wire                              tx_we,
  input  wire                              arp_we,
  output logic [fabric_pkg::TX_W-1:0]      tx_rd_word,
  output logic [fabric_pkg::TX_W-1:0]      rx_rd_word,
  output logic [fabric_pkg::ARP_W-1:0]     arp_rd_word,
  input  wire [fabric_pkg::BUF_AW-1:0]     net_tx_addr,
  output logic [fabric_pkg::TX_W-1:0]      net_tx_data,
  input  wire                              rx_wr_en,
  input  wire [fabric_pkg::BUF_AW-1:0]     rx_wr_addr,
  input  wire [fabric_pkg::TX_W-1:0]       rx_wr_data,
  input  wire [fabric_pkg::BUF_AW-1:0]     arp_lookup_addr,
  output logic [fabric_pkg::ARP_W-1:0]     arp_lookup_mac
);

  localparam int depth = 2 ** fabric_pkg::BUF_AW;

  logic [fabric_pkg::TX_W-1:0]  tx_mem  [depth];
  logic [fabric_pkg::TX_W-1:0]  rx_mem  [depth];
  logic [fabric_pkg::ARP_W-1:0] arp_mem [depth];

  // cpu fills the transmit buffer
  always_ff @(posedge OPB_Clk) begin
    if (tx_we) begin
      tx_mem[buf_addr] <= wr_word;
    end
  end

  // network fills the receive buffer
  always_ff @(posedge OPB_Clk) begin
    if (rx_wr_en) begin
      rx_mem[rx_wr_addr] <= rx_wr_data;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (arp_we) begin
      arp_mem[buf_addr] <= wr_word[fabric_pkg::ARP_W-1:0];
    end
  end

  // bus side reads
  assign tx_rd_word  = tx_mem[buf_addr];
  assign rx_rd_word  = rx_mem[buf_addr];
  assign arp_rd_word = arp_mem[buf_addr];

  // network side reads
  assign net_tx_data    = tx_mem[net_tx_addr];
  assign arp_lookup_mac = arp_mem[arp_lookup_addr];

endmodule

`default_nettype wire

/* hdl/fabric_cpu_if.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_cpu_if #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_3fff,
  parameter fabric_pkg::local_cfg_t default_cfg = '{
    mac:     48'h0200_0000_0001,
    ip:      32'h0a00_0001,
    port:    16'hea60,
    gateway: 8'd1,
    enable:  1'b0
  }
) (
  input  wire                              OPB_Clk,
  input  wire                              reset,
  input  wire                              opb_select,
  input  wire                              opb_rnw,
  input  wire [3:0]                        opb_be,
  input  wire [31:0]                       opb_abus,
  input  wire [31:0]                       opb_dbus,
  output logic [31:0]                      sl_dbus,
  output logic                             sl_xfer_ack,
  input  wire [fabric_pkg::BUF_AW-1:0]     net_tx_addr,
  output logic [fabric_pkg::TX_W-1:0]      net_tx_data,
  input  wire                              rx_wr_en,
  input  wire [fabric_pkg::BUF_AW-1:0]     rx_wr_addr,
  input  wire [fabric_pkg::TX_W-1:0]       rx_wr_data,
  input  wire [fabric_pkg::BUF_AW-1:0]     arp_lookup_addr,
  output logic [fabric_pkg::ARP_W-1:0]     arp_lookup_mac,
  output logic [7:0]                       tx_size,
  output logic                             tx_ready,
  input  wire                              tx_done,
  input  wire [7:0]                        rx_size,
  output logic                             rx_ack,
  input  wire [7:0]                        xaui_status,
  output fabric_pkg::local_cfg_t           local_cfg,
  output fabric_pkg::phy_cfg_t             phy_cfg
);

  logic                             trans;
  fabric_pkg::opb_req_t             req;
  logic [31:0]                      reg_rdata;
  logic [fabric_pkg::BUF_AW-1:0]    buf_addr;
  logic [fabric_pkg::TX_W-1:0]      wr_word;
  logic                             tx_we;
  logic                             arp_we;
  logic [fabric_pkg::TX_W-1:0]      tx_rd_word;
  logic [fabric_pkg::TX_W-1:0]      rx_rd_word;
  logic [fabric_pkg::ARP_W-1:0]     arp_rd_word;

  opb_decode #(
    .base_addr (base_addr),
    .high_addr (high_addr)
  ) u_decode (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .opb_select (opb_select),
    .opb_rnw    (opb_rnw),
    .opb_be     (opb_be),
    .opb_abus   (opb_abus),
    .opb_dbus   (opb_dbus),
    .trans      (trans),
    .req        (req),
    .xfer_ack   (sl_xfer_ack)
  );

  fabric_regs #(
    .default_cfg (default_cfg)
  ) u_regs (
    .OPB_Clk     (OPB_Clk),
    .reset       (reset),
    .trans       (trans),
    .req         (req),
    .tx_done     (tx_done),
    .rx_size     (rx_size),
    .xaui_status (xaui_status),
    .local_cfg   (local_cfg),
    .phy_cfg     (phy_cfg),
    .tx_size     (tx_size),
    .tx_ready    (tx_ready),
    .rx_ack      (rx_ack),
    .reg_rdata   (reg_rdata)
  );

  buffer_port u_buf_port (
    .OPB_Clk     (OPB_Clk),
    .reset       (reset),
    .trans       (trans),
    .req         (req),
    .tx_rd_word  (tx_rd_word),
    .arp_rd_word (arp_rd_word),
    .buf_addr    (buf_addr),
    .wr_word     (wr_word),
    .tx_we       (tx_we),
    .arp_we      (arp_we)
  );

  read_return u_read (
    .OPB_Clk     (OPB_Clk),
    .reset       (reset),
    .trans       (trans),
    .req         (req),
    .xfer_ack    (sl_xfer_ack),
    .reg_rdata   (reg_rdata),
    .tx_rd_word  (tx_rd_word),
    .rx_rd_word  (rx_rd_word),
    .arp_rd_word (arp_rd_word),
    .sl_dbus     (sl_dbus)
  );

  cpu_buffers u_buffers (
    .OPB_Clk         (OPB_Clk),
    .buf_addr        (buf_addr),
    .wr_word         (wr_word),
    .tx_we           (tx_we),
    .arp_we          (arp_we),
    .tx_rd_word      (tx_rd_word),
    .rx_rd_word      (rx_rd_word),
    .arp_rd_word     (arp_rd_word),
    .net_tx_addr     (net_tx_addr),
    .net_tx_data     (net_tx_data),
    .rx_wr_en        (rx_wr_en),
    .rx_wr_addr      (rx_wr_addr),
    .rx_wr_data      (rx_wr_data),
    .arp_lookup_addr (arp_lookup_addr),
    .arp_lookup_mac  (arp_lookup_mac)
  );

endmodule

`default_nettype wire

/* hdl/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

  localparam int BUF_AW = 8;
  localparam int TX_W   = 64;
  localparam int ARP_W  = 48;

  // 2 KB windows, only every other one is populated
  localparam int unsigned win_shift = 11;
  localparam logic [20:0] win_regs  = 21'd0;
  localparam logic [20:0] win_tx    = 21'd2;
  localparam logic [20:0] win_rx    = 21'd4;
  localparam logic [20:0] win_arp   = 21'd6;

  typedef enum logic [2:0] {
    rgn_none,
    rgn_regs,
    rgn_tx,
    rgn_rx,
    rgn_arp
  } region_e;

  typedef enum logic [3:0] {
    mac_hi      = 4'd0,
    mac_lo      = 4'd1,
    gateway     = 4'd3,
    ip          = 4'd4,
    buf_sizes   = 4'd6,
    ports       = 4'd8,
    xaui_status = 4'd9,
    phy_config  = 4'd10
  } reg_idx_e;

  typedef struct packed {
    logic        rnw;
    logic [3:0]  be;
    region_e     region;
    logic [10:0] offset;
    logic [31:0] wdata;
  } opb_req_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic [7:0]  gateway;
    logic        enable;
  } local_cfg_t;

  typedef struct packed {
    logic [1:0] rxeqmix;
    logic [3:0] rxeqpole;
    logic [2:0] txpreemphasis;
    logic [2:0] txdiffctrl;
  } phy_cfg_t;

  localparam phy_cfg_t phy_default = '{
    rxeqmix:       2'd0,
    rxeqpole:      4'd0,
    txpreemphasis: 3'd0,
    txdiffctrl:    3'd4
  };

  // overlay the enabled bus bytes on a word
  function automatic logic [31:0] be_merge(input logic [31:0] cur,
                                           input logic [31:0] wd,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wd[8*i +: 8];
      end
    end
    return res;
  endfunction

  // offset bit 2 set means the low word
  function automatic logic [31:0] half_sel(input logic [63:0] word, input logic lo);
    return lo ? word[31:0] : word[63:32];
  endfunction

endpackage

`default_nettype wire

/* hdl/fabric_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_regs #(
  parameter fabric_pkg::local_cfg_t default_cfg = '0
) (
  input  wire                     OPB_Clk,
  input  wire                     reset,
  input  wire                     trans,
  input  wire fabric_pkg::opb_req_t req,
  input  wire                     tx_done,
  input  wire [7:0]               rx_size,
  input  wire [7:0]               xaui_status,
  output fabric_pkg::local_cfg_t  local_cfg,
  output fabric_pkg::phy_cfg_t    phy_cfg,
  output logic [7:0]              tx_size,
  output logic                    tx_ready,
  output logic                    rx_ack,
  output logic [31:0]             reg_rdata
);

  fabric_pkg::reg_idx_e idx;
  logic                 wr;
  logic [31:0]          merged;

  assign idx = fabric_pkg::reg_idx_e'(req.offset[5:2]);
  assign wr  = trans && !req.rnw && (req.region == fabric_pkg::rgn_regs);

  // read image of the addressed register with the written bytes laid over it
  assign merged = fabric_pkg::be_merge(reg_rdata, req.wdata, req.be);

  always_comb begin
    case (idx)
      fabric_pkg::mac_hi:      reg_rdata = {16'b0, local_cfg.mac[47:32]};
      fabric_pkg::mac_lo:      reg_rdata = local_cfg.mac[31:0];
      fabric_pkg::gateway:     reg_rdata = {24'b0, local_cfg.gateway};
      fabric_pkg::ip:          reg_rdata = local_cfg.ip;
      fabric_pkg::buf_sizes:   reg_rdata = {8'b0, tx_size, 8'b0, rx_ack ? 8'b0 : rx_size};
      fabric_pkg::ports:       reg_rdata = {15'b0, local_cfg.enable, local_cfg.port};
      fabric_pkg::xaui_status: reg_rdata = {24'b0, xaui_status};
      fabric_pkg::phy_config: begin
        reg_rdata = {5'b0, phy_cfg.txdiffctrl,
                     5'b0, phy_cfg.txpreemphasis,
                     4'b0, phy_cfg.rxeqpole,
                     6'b0, phy_cfg.rxeqmix};
      end
      default:                 reg_rdata = 32'b0;
    endcase
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      local_cfg <= default_cfg;
      phy_cfg   <= fabric_pkg::phy_default;
      tx_size   <= 8'd0;
      tx_ready  <= 1'b0;
      rx_ack    <= 1'b0;
    end else begin
      // frame has gone out
      if (tx_done) begin
        tx_size  <= 8'd0;
        tx_ready <= 1'b0;
      end
      // network side swapped its buffers
      if (rx_size == 8'd0) begin
        rx_ack <= 1'b0;
      end
      if (wr) begin
        case (idx)
          fabric_pkg::mac_hi: begin
            local_cfg.mac[47:32] <= merged[15:0];
          end
          fabric_pkg::mac_lo: begin
            local_cfg.mac[31:0] <= merged;
          end
          fabric_pkg::gateway: begin
            local_cfg.gateway <= merged[7:0];
          end
          fabric_pkg::ip: begin
            local_cfg.ip <= merged;
          end
          fabric_pkg::buf_sizes: begin
            if (req.be[0]) begin
              rx_ack <= 1'b1;
            end
            // a new size simply replaces a pending one
            if (req.be[2]) begin
              tx_size  <= req.wdata[23:16];
              tx_ready <= 1'b1;
            end
          end
          fabric_pkg::ports: begin
            local_cfg.port   <= merged[15:0];
            local_cfg.enable <= merged[16];
          end
          fabric_pkg::phy_config: begin
            phy_cfg.rxeqmix       <= merged[1:0];
            phy_cfg.rxeqpole      <= merged[11:8];
            phy_cfg.txpreemphasis <= merged[18:16];
            phy_cfg.txdiffctrl    <= merged[26:24];
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/opb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module opb_decode #(
  parameter logic [31:0] base_addr = 32'h0000_0000,
  parameter logic [31:0] high_addr = 32'h0000_3fff
) (
  input  wire                   OPB_Clk,
  input  wire                   reset,
  input  wire                   opb_select,
  input  wire                   opb_rnw,
  input  wire [3:0]             opb_be,
  input  wire [31:0]            opb_abus,
  input  wire [31:0]            opb_dbus,
  output logic                  trans,
  output fabric_pkg::opb_req_t  req,
  output logic                  xfer_ack
);

  logic [31:0]         local_addr;
  logic                in_window;
  fabric_pkg::region_e region;

  assign local_addr = opb_abus - base_addr;
  assign in_window  = (opb_abus >= base_addr) && (opb_abus <= high_addr);

  // master still holds select during the ack cycle
  assign trans = opb_select && in_window && !xfer_ack;

  always_comb begin
    case (local_addr[31:fabric_pkg::win_shift])
      fabric_pkg::win_regs: region = fabric_pkg::rgn_regs;
      fabric_pkg::win_tx:   region = fabric_pkg::rgn_tx;
      fabric_pkg::win_rx:   region = fabric_pkg::rgn_rx;
      fabric_pkg::win_arp:  region = fabric_pkg::rgn_arp;
      default:              region = fabric_pkg::rgn_none;
    endcase
  end

  assign req = '{
    rnw:    opb_rnw,
    be:     opb_be,
    region: region,
    offset: local_addr[10:0],
    wdata:  opb_dbus
  };

  // one ack per strobe
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      xfer_ack <= 1'b0;
    end else begin
      xfer_ack <= trans;
    end
  end

endmodule

`default_nettype wire

/* hdl/read_return.sv */
`timescale 1ns/1ps
`default_nettype none

module read_return (
  input  wire                         OPB_Clk,
  input  wire                         reset,
  input  wire                         trans,
  input  wire fabric_pkg::opb_req_t   req,
  input  wire                         xfer_ack,
  input  wire [31:0]                  reg_rdata,
  input  wire [fabric_pkg::TX_W-1:0]  tx_rd_word,
  input  wire [fabric_pkg::TX_W-1:0]  rx_rd_word,
  input  wire [fabric_pkg::ARP_W-1:0] arp_rd_word,
  output logic [31:0]                 sl_dbus
);

  fabric_pkg::region_e src;
  logic                lo;
  logic [31:0]         word;

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      src <= fabric_pkg::rgn_none;
    end else if (trans) begin
      src <= req.region;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (trans) begin
      lo <= req.offset[2];
    end
  end

  // address is still held by the master while ack is up
  always_comb begin
    case (src)
      fabric_pkg::rgn_regs: word = reg_rdata;
      fabric_pkg::rgn_tx:   word = fabric_pkg::half_sel(tx_rd_word, lo);
      fabric_pkg::rgn_rx:   word = fabric_pkg::half_sel(rx_rd_word, lo);
      fabric_pkg::rgn_arp:  word = fabric_pkg::half_sel({16'b0, arp_rd_word}, lo);
      default:              word = 32'b0;
    endcase
  end

  assign sl_dbus = xfer_ack ? word : 32'b0;

endmodule

`default_nettype wire

/* sources.f */
hdl/fabric_pkg.sv
hdl/opb_decode.sv
hdl/fabric_regs.sv
hdl/buffer_port.sv
hdl/read_return.sv
hdl/cpu_buffers.sv
hdl/fabric_cpu_if.sv
verification/fabric_cpu_checker.sv
verification/tb_fabric_cpu_if.sv

/* verification/fabric_cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_cpu_checker (
  input wire        OPB_Clk,
  input wire        reset,
  input wire        sl_xfer_ack,
  input wire [31:0] sl_dbus,
  input wire        tx_ready,
  input wire        tx_done
);

  int unsigned assert_fails = 0;

  // master drops select right after the ack
  ack_one_cycle: assert property (@(posedge OPB_Clk) disable iff (reset)
    sl_xfer_ack |=> !sl_xfer_ack)
    else begin
      assert_fails++;
      $error("xfer_ack stayed high for two cycles");
    end

  dbus_idle_zero: assert property (@(posedge OPB_Clk) disable iff (reset)
    !sl_xfer_ack |-> (sl_dbus == 32'b0))
    else begin
      assert_fails++;
      $error("sl_dbus not zero outside xfer_ack");
    end

  // only the network side releases the transmit buffer
  tx_ready_release: assert property (@(posedge OPB_Clk) disable iff (reset)
    $fell(tx_ready) |-> $past(tx_done))
    else begin
      assert_fails++;
      $error("tx_ready fell without tx_done");
    end

endmodule

bind fabric_cpu_if fabric_cpu_checker u_checker (
  .OPB_Clk     (OPB_Clk),
  .reset       (reset),
  .sl_xfer_ack (sl_xfer_ack),
  .sl_dbus     (sl_dbus),
  .tx_ready    (tx_ready),
  .tx_done     (tx_done)
);

`default_nettype wire

/* verification/tb_fabric_cpu_if.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fabric_cpu_if;

  localparam int timeout_cycles = 20;

  localparam logic [2:0] op_wr     = 3'd0;
  localparam logic [2:0] op_rd     = 3'd1;
  localparam logic [2:0] op_txdone = 3'd2;
  localparam logic [2:0] op_rxfill = 3'd3;
  localparam logic [2:0] op_rxsize = 3'd4;
  localparam logic [2:0] op_peek   = 3'd5;
  localparam logic [2:0] op_noack  = 3'd6;

  // peek codes, bits 11:8 pick the port, bits 7:0 a memory word
  localparam logic [31:0] pk_mac = 32'h000;
  localparam logic [31:0] pk_cfg = 32'h100;
  localparam logic [31:0] pk_phy = 32'h200;
  localparam logic [31:0] pk_ctl = 32'h300;
  localparam logic [31:0] pk_tx  = 32'h400;
  localparam logic [31:0] pk_arp = 32'h500;

  localparam fabric_pkg::local_cfg_t reset_cfg = '{
    mac:     48'h0a35_0102_0304,
    ip:      32'hc0a8_0110,
    port:    16'h1f90,
    gateway: 8'hfe,
    enable:  1'b1
  };

  typedef struct packed {
    logic [3:0]  test;
    logic [2:0]  op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [63:0] data;
    logic [63:0] expected;
  } step_t;

  logic        OPB_Clk;
  logic        reset;
  logic        opb_select;
  logic        opb_rnw;
  logic [3:0]  opb_be;
  logic [31:0] opb_abus;
  logic [31:0] opb_dbus;
  logic [31:0] sl_dbus;
  logic        sl_xfer_ack;
  logic [7:0]  net_tx_addr;
  logic [63:0] net_tx_data;
  logic        rx_wr_en;
  logic [7:0]  rx_wr_addr;
  logic [63:0] rx_wr_data;
  logic [7:0]  arp_lookup_addr;
  logic [47:0] arp_lookup_mac;
  logic [7:0]  tx_size;
  logic        tx_ready;
  logic        tx_done;
  logic [7:0]  rx_size;
  logic        rx_ack;
  logic [7:0]  xaui_status;
  fabric_pkg::local_cfg_t local_cfg;
  fabric_pkg::phy_cfg_t   phy_cfg;

  // shadow model of the register set and memories
  fabric_pkg::local_cfg_t cfg_s;
  fabric_pkg::phy_cfg_t   phy_s;
  logic [7:0]  txsize_s;
  logic [7:0]  rxsize_s;
  logic        txready_s;
  logic        rxack_s;
  logic [63:0] txmem_s [256];
  logic [63:0] rx_s [256];
  logic [47:0] arp_s [256];

  step_t  steps [$];
  integer seed;
  int     checks;
  int     errors;
  int     reg_list [8] = '{0, 1, 3, 4, 6, 8, 9, 10};

  fabric_cpu_if #(
    .default_cfg (reset_cfg)
  ) i_dut (.*);

  initial begin
    OPB_Clk = 1'b0;
    forever #50 OPB_Clk = ~OPB_Clk;
  end

  function automatic string test_name(input int t);
    case (t)
      1: return "reset defaults";
      2: return "register byte enables";
      3: return "tx buffer merge";
      4: return "arp cache merge";
      5: return "rx buffer and rx_ack";
      6: return "tx control and window";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [7:0] w;
    w = addr[10:3];
    case (addr[13:11])
      3'd0: begin
        case (addr[5:2])
          4'd0: return {16'b0, cfg_s.mac[47:32]};
          4'd1: return cfg_s.mac[31:0];
          4'd3: return {24'b0, cfg_s.gateway};
          4'd4: return cfg_s.ip;
          4'd6: return {8'b0, txsize_s, 8'b0, rxack_s ? 8'b0 : rxsize_s};
          4'd8: return {15'b0, cfg_s.enable, cfg_s.port};
          4'd9: return {24'b0, xaui_status};
          4'd10: begin
            return {5'b0, phy_s.txdiffctrl, 5'b0, phy_s.txpreemphasis,
                    4'b0, phy_s.rxeqpole, 6'b0, phy_s.rxeqmix};
          end
          default: return 32'b0;
        endcase
      end
      3'd2: return addr[2] ? txmem_s[w][31:0] : txmem_s[w][63:32];
      3'd4: return addr[2] ? rx_s[w][31:0] : rx_s[w][63:32];
      3'd6: return addr[2] ? arp_s[w][31:0] : {16'b0, arp_s[w][47:32]};
      default: return 32'b0;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
    logic [31:0] img;
    logic [7:0]  w;
    img = model_read(addr);
    w = addr[10:3];
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        img[8*i +: 8] = data[8*i +: 8];
      end
    end
    if (addr[13:11] == 3'd0) begin
      case (addr[5:2])
        4'd0: cfg_s.mac[47:32] = img[15:0];
        4'd1: cfg_s.mac[31:0] = img;
        4'd3: cfg_s.gateway = img[7:0];
        4'd4: cfg_s.ip = img;
        4'd6: begin
          if (be[0]) begin
            rxack_s = 1'b1;
          end
          if (be[2]) begin
            txsize_s = data[23:16];
            txready_s = 1'b1;
          end
        end
        4'd8: {cfg_s.enable, cfg_s.port} = img[16:0];
        4'd10: begin
          phy_s.rxeqmix = img[1:0];
          phy_s.rxeqpole = img[11:8];
          phy_s.txpreemphasis = img[18:16];
          phy_s.txdiffctrl = img[26:24];
        end
        default: ;
      endcase
    end else if (addr[13:11] == 3'd2) begin
      if (addr[2]) txmem_s[w][31:0] = img;
      else txmem_s[w][63:32] = img;
    end else if (addr[13:11] == 3'd6) begin
      // upper entry half is only 16 bits wide
      if (addr[2]) arp_s[w][31:0] = img;
      else arp_s[w][47:32] = img[15:0];
    end
  endtask

  function automatic logic [63:0] model_peek(input logic [31:0] code);
    case (code[11:8])
      4'd0: return {16'b0, cfg_s.mac};
      4'd1: return {7'b0, cfg_s.ip, cfg_s.port, cfg_s.gateway, cfg_s.enable};
      4'd2: return {52'b0, phy_s};
      4'd3: return {54'b0, rxack_s, txready_s, txsize_s};
      4'd4: return txmem_s[code[7:0]];
      default: return {16'b0, arp_s[code[7:0]]};
    endcase
  endfunction

  function automatic logic [63:0] dut_peek(input logic [31:0] code);
    case (code[11:8])
      4'd0: return {16'b0, local_cfg.mac};
      4'd1: return {7'b0, local_cfg.ip, local_cfg.port, local_cfg.gateway, local_cfg.enable};
      4'd2: return {52'b0, phy_cfg};
      4'd3: return {54'b0, rx_ack, tx_ready, tx_size};
      4'd4: return net_tx_data;
      default: return {16'b0, arp_lookup_mac};
    endcase
  endfunction

  function automatic string peek_name(input logic [31:0] code);
    case (code[11:8])
      4'd0: return "local_cfg.mac";
      4'd1: return "local_cfg";
      4'd2: return "phy_cfg";
      4'd3: return "{rx_ack,tx_ready,tx_size}";
      4'd4: return $sformatf("net_tx_data[%0d]", code[7:0]);
      default: return $sformatf("arp_lookup_mac[%0d]", code[7:0]);
    endcase
  endfunction

  task automatic add_step(input int test, input logic [2:0] op, input logic [31:0] addr,
                          input logic [3:0] be, input logic [63:0] data);
    step_t s;
    s = '{test: 4'(test), op: op, addr: addr, be: be, data: data, expected: 64'b0};
    case (op)
      op_wr: model_write(addr, be, data[31:0]);
      op_rd: s.expected = {32'b0, model_read(addr)};
      op_txdone: begin
        txsize_s = 8'd0;
        txready_s = 1'b0;
      end
      op_rxfill: rx_s[addr[7:0]] = data;
      op_rxsize: begin
        rxsize_s = data[7:0];
        if (data[7:0] == 8'd0) begin
          rxack_s = 1'b0;
        end
      end
      op_peek: s.expected = model_peek(addr);
      default: ;
    endcase
    steps.push_back(s);
  endtask

  task automatic compare(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic bus_xfer(input logic rnw, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] data, input logic want_ack,
                          output logic [31:0] rdata);
    int   n;
    logic acked;
    opb_select = 1'b1;
    opb_rnw = rnw;
    opb_be = be;
    opb_abus = addr;
    opb_dbus = data;
    acked = 1'b0;
    rdata = 32'b0;
    n = 0;
    while (!acked && n < timeout_cycles) begin
      @(negedge OPB_Clk);
      if (sl_xfer_ack) begin
        acked = 1'b1;
        rdata = sl_dbus;
      end
      n++;
    end
    checks++;
    if (want_ack && !acked) begin
      errors++;
      $display("no xfer_ack within %0d cycles for address %h", timeout_cycles, addr);
    end else if (!want_ack && acked) begin
      errors++;
      $display("address %h is outside the window but got xfer_ack", addr);
    end
    @(posedge OPB_Clk);
    #5;
    opb_select = 1'b0;
    opb_rnw = 1'b1;
    opb_be = 4'b0;
    opb_abus = 32'b0;
    opb_dbus = 32'b0;
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rdata;
    case (s.op)
      op_wr: bus_xfer(1'b0, s.addr, s.be, s.data[31:0], 1'b1, rdata);
      op_rd: begin
        bus_xfer(1'b1, s.addr, 4'hf, 32'b0, 1'b1, rdata);
        compare($sformatf("sl_dbus[%h]", s.addr), s.expected, {32'b0, rdata});
      end
      op_noack: bus_xfer(1'b1, s.addr, 4'hf, 32'b0, 1'b0, rdata);
      op_txdone: begin
        tx_done = 1'b1;
        @(posedge OPB_Clk);
        #5;
        tx_done = 1'b0;
      end
      op_rxfill: begin
        rx_wr_en = 1'b1;
        rx_wr_addr = s.addr[7:0];
        rx_wr_data = s.data;
        @(posedge OPB_Clk);
        #5;
        rx_wr_en = 1'b0;
      end
      op_rxsize: rx_size = s.data[7:0];
      default: begin
        net_tx_addr = s.addr[7:0];
        arp_lookup_addr = s.addr[7:0];
        @(negedge OPB_Clk);
        compare(peek_name(s.addr), s.expected, dut_peek(s.addr));
      end
    endcase
  endtask

  task automatic build_table();
    logic [31:0] targets [6];
    logic [3:0]  fixed_be [6];
    logic [3:0]  mask;
    logic [7:0]  w;
    logic [31:0] a;
    for (int i = 0; i < 4; i++) begin
      add_step(1, op_peek, 32'h100 * i, 4'h0, 64'b0);
    end
    foreach (reg_list[i]) begin
      add_step(1, op_rd, 4 * reg_list[i], 4'hf, 64'b0);
    end
    targets = '{32'h00, 32'h04, 32'h0c, 32'h10, 32'h20, 32'h28};
    fixed_be = '{4'b0010, 4'b0101, 4'b1111, 4'b1001, 4'b0110, 4'b1010};
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 6; i++) begin
        mask = (round == 0) ? fixed_be[i] : 4'($random(seed));
        add_step(2, op_wr, targets[i], mask, {32'b0, $random(seed)});
        add_step(2, op_rd, targets[i], 4'hf, 64'b0);
        add_step(2, op_peek, (i == 5) ? pk_phy : ((i < 2) ? pk_mac : pk_cfg), 4'h0, 64'b0);
      end
    end
    // full words first, then partial halves on top
    for (int i = 0; i < 16; i++) begin
      a = 32'h1000 + 8 * (((i % 8) / 2) * 37 + 5) + 4 * (i % 2);
      mask = (i < 8) ? 4'hf : 4'($random(seed));
      add_step(3, op_wr, a, mask, {32'b0, $random(seed)});
    end
    for (int k = 0; k < 4; k++) begin
      w = 8'(k * 37 + 5);
      add_step(3, op_peek, pk_tx + w, 4'h0, 64'b0);
      add_step(3, op_rd, 32'h1000 + 8 * w, 4'hf, 64'b0);
      add_step(3, op_rd, 32'h1000 + 8 * w + 4, 4'hf, 64'b0);
    end
    for (int k = 0; k < 3; k++) begin
      a = 32'h3000 + 8 * (k * 91 + 2);
      add_step(4, op_wr, a, 4'hf, {32'b0, $random(seed)});
      add_step(4, op_wr, a + 4, 4'hf, {32'b0, $random(seed)});
      add_step(4, op_wr, a, 4'b1110, {32'b0, $random(seed)});
      add_step(4, op_wr, a + 4, 4'($random(seed)), {32'b0, $random(seed)});
      add_step(4, op_peek, pk_arp + (k * 91 + 2), 4'h0, 64'b0);
      add_step(4, op_rd, a, 4'hf, 64'b0);
      add_step(4, op_rd, a + 4, 4'hf, 64'b0);
    end
    for (int k = 0; k < 3; k++) begin
      a = 32'h2000 + 8 * (k * 53 + 7);
      add_step(5, op_rxfill, k * 53 + 7, 4'h0, {$random(seed), $random(seed)});
      add_step(5, op_rd, a, 4'hf, 64'b0);
      add_step(5, op_rd, a + 4, 4'hf, 64'b0);
    end
    add_step(5, op_rxsize, 32'b0, 4'h0, 64'h2a);
    add_step(5, op_rd, 32'h18, 4'hf, 64'b0);
    add_step(5, op_wr, 32'h18, 4'b0001, 64'h0);
    add_step(5, op_rd, 32'h18, 4'hf, 64'b0);
    add_step(5, op_peek, pk_ctl, 4'h0, 64'b0);
    add_step(5, op_rxsize, 32'b0, 4'h0, 64'h0);
    add_step(5, op_peek, pk_ctl, 4'h0, 64'b0);
    add_step(5, op_rxsize, 32'b0, 4'h0, 64'h11);
    add_step(5, op_rd, 32'h18, 4'hf, 64'b0);
    add_step(6, op_wr, 32'h18, 4'b0100, {32'b0, 32'h0040_0000 | ($random(seed) & 32'hff00_ffff)});
    add_step(6, op_peek, pk_ctl, 4'h0, 64'b0);
    add_step(6, op_rd, 32'h18, 4'hf, 64'b0);
    add_step(6, op_wr, 32'h18, 4'b0100, 64'h0077_0000);
    add_step(6, op_peek, pk_ctl, 4'h0, 64'b0);
    add_step(6, op_txdone, 32'b0, 4'h0, 64'b0);
    add_step(6, op_peek, pk_ctl, 4'h0, 64'b0);
    add_step(6, op_rd, 32'h18, 4'hf, 64'b0);
    add_step(6, op_noack, 32'h0000_4000, 4'hf, 64'b0);
    add_step(6, op_noack, 32'h8000_0010, 4'hf, 64'b0);
  endtask

  initial begin
    int cur_test;
    int test_checks;
    int test_errors;
    reset = 1'b1;
    opb_select = 1'b0;
    opb_rnw = 1'b1;
    opb_be = 4'b0;
    opb_abus = 32'b0;
    opb_dbus = 32'b0;
    net_tx_addr = 8'd0;
    rx_wr_en = 1'b0;
    rx_wr_addr = 8'd0;
    rx_wr_data = 64'b0;
    arp_lookup_addr = 8'd0;
    tx_done = 1'b0;
    rx_size = 8'd0;
    xaui_status = 8'h5a;
    seed = 55;
    checks = 0;
    errors = 0;
    cur_test = 0;
    test_checks = 0;
    test_errors = 0;
    cfg_s = reset_cfg;
    phy_s.rxeqmix = 2'd0;
    phy_s.rxeqpole = 4'd0;
    phy_s.txpreemphasis = 3'd0;
    phy_s.txdiffctrl = 3'd4;
    txsize_s = 8'd0;
    rxsize_s = 8'd0;
    txready_s = 1'b0;
    rxack_s = 1'b0;
    build_table();
    repeat (8) @(posedge OPB_Clk);
    #5;
    reset = 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      if (int'(steps[i].test) != cur_test) begin
        if (cur_test != 0) begin
          $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
                   checks - test_checks, errors - test_errors);
        end
        cur_test = steps[i].test;
        test_checks = checks;
        test_errors = errors;
      end
      @(posedge OPB_Clk);
      #5;
      run_step(steps[i]);
    end
    $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
             checks - test_checks, errors - test_errors);
    repeat (2) @(posedge OPB_Clk);
    errors += i_dut.u_checker.assert_fails;
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             i_dut.u_checker.assert_fails);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
